/* dp_link_pkg.sv */
package dp_link_pkg;

    localparam int SYM_W = 8;   // Symbol width
    localparam int LANES = 4;   // Lane maximum
    localparam int SPL   = 2;   // Symbols per lane per clock

    // One lane per clock, sublane 0 carries the earlier symbol
    typedef struct packed {
        logic [SPL-1:0]            msa;     // MSA flag per sublane
        logic [SPL-1:0][SYM_W-1:0] dat;
    } lane_sym_t;

    typedef struct packed {
        logic                  lock;
        lane_sym_t [LANES-1:0] lane;
    } lnk_beat_t;

    // Two symbols in send order
    typedef struct packed {
        logic [SYM_W-1:0] first;
        logic [SYM_W-1:0] second;
    } sym_pair_t;

    // Sublane that carried the first MSA symbol
    typedef enum logic {
        PHASE_0,
        PHASE_1
    } msa_phase_t;

endpackage

/* msa_pkg.sv */
package msa_pkg;

    localparam int MSG_IDX_W = 5;   // Message index width
    localparam int MSG_DAT_W = 16;  // Message data width

    // Active lane count as seen on the control input
    typedef enum logic [1:0] {
        LANES_1 = 2'd1,
        LANES_2 = 2'd2,
        LANES_4 = 2'd3
    } lanes_cfg_t;

    // Read request from the message side
    typedef struct packed {
        logic [MSG_IDX_W-1:0] idx;
        logic                 first;    // Start of a new message
    } msg_req_t;

    typedef struct packed {
        logic [MSG_DAT_W-1:0] dat;
    } msg_rsp_t;

endpackage

/* msa_sym_ram.sv */
module msa_sym_ram
#(
    parameter int P_RAM_DEPTH = 32
)
(
    input  logic                           CLK_IN,
    input  logic                           wr,
    input  logic [$clog2(P_RAM_DEPTH)-1:0] wr_addr,
    input  logic [7:0]                     wr_data,
    input  logic [$clog2(P_RAM_DEPTH)-1:0] rd_addr,
    output logic [7:0]                     rd_data
);

    logic [7:0] mem [P_RAM_DEPTH];

    always_ff @(posedge CLK_IN)
    begin
        if (wr)
            mem[wr_addr] <= wr_data;
    end

    // Read port is asynchronous, data follows the address in the same cycle
    assign rd_data = mem[rd_addr];

endmodule

/* msa_lane_capture.sv */
module msa_lane_capture
#(
    parameter int P_RAM_DEPTH = 32
)
(
    input  logic                        CLK_IN,
    input  logic                        rst_n,
    input  dp_link_pkg::lane_sym_t      beat,
    input  logic [dp_link_pkg::SPL-1:0] rd,     // Logical strobes, bit 0 is first
    output dp_link_pkg::sym_pair_t      pair,
    output logic                        eop
);

    import dp_link_pkg::*;

    localparam int AW = $clog2(P_RAM_DEPTH);

    logic                      msa_any;
    logic                      msa_q;
    logic                      sop;
    msa_phase_t                phase;
    logic [SPL-1:0][AW-1:0]    wp;          // Write pointers per sublane
    logic [SPL-1:0][AW-1:0]    rp;          // Read pointers per sublane
    logic [SPL-1:0]            ram_rd;      // Physical read strobes
    logic [SPL-1:0][SYM_W-1:0] ram_dat;

    // Packet edges on the merged sublane flags
    assign msa_any = |beat.msa;
    assign sop     = msa_any & ~msa_q;
    assign eop     = ~msa_any & msa_q;

    always_ff @(posedge CLK_IN or negedge rst_n)
    begin
        if (!rst_n)
        begin
            msa_q <= 1'b0;
            phase <= PHASE_0;
        end
        else
        begin
            msa_q <= msa_any;
            // Packet started on the odd sublane
            if (sop)
                phase <= (beat.msa[1] && !beat.msa[0]) ? PHASE_1 : PHASE_0;
        end
    end

    always_ff @(posedge CLK_IN or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wp <= '0;
            rp <= '0;
        end
        else
        begin
            for (int j = 0; j < SPL; j++)
            begin
                wp[j] <= beat.msa[j] ? wp[j] + 1'b1 : '0;   // Restart on every gap
                if (eop)
                    rp[j] <= '0;
                else if (ram_rd[j])
                    rp[j] <= rp[j] + 1'b1;
            end
        end
    end

    // Swap sublanes in phase 1 so the pair comes out in send order
    always_comb
    begin
        if (phase == PHASE_1)
        begin
            ram_rd      = {rd[0], rd[1]};
            pair.first  = ram_dat[1];
            pair.second = ram_dat[0];
        end
        else
        begin
            ram_rd      = rd;
            pair.first  = ram_dat[0];
            pair.second = ram_dat[1];
        end
    end

    for (genvar j = 0; j < SPL; j++)
    begin : gen_ram
        msa_sym_ram #(
            .P_RAM_DEPTH (P_RAM_DEPTH)
        ) ram_inst (
            .CLK_IN  (CLK_IN),
            .wr      (beat.msa[j]),
            .wr_addr (wp[j]),
            .wr_data (beat.dat[j]),
            .rd_addr (rp[j]),
            .rd_data (ram_dat[j])
        );
    end

    // A packet needs at least one flagged beat between its edges
    a_sop_eop_excl : assert property (@(posedge CLK_IN) disable iff (!rst_n)
        !(sop && eop));

endmodule

/* msa_read_mux.sv */
module msa_read_mux
(
    input  logic                       CLK_IN,
    input  logic                       rst_n,
    input  msa_pkg::lanes_cfg_t        ctl_lanes,
    input  msa_pkg::msg_req_t          req,
    input  logic                       req_valid,
    input  logic                       rsp_ready,
    input  dp_link_pkg::sym_pair_t     pair [dp_link_pkg::LANES],
    output logic                       req_ready,
    output msa_pkg::msg_rsp_t          rsp,
    output logic                       rsp_valid,
    output logic [dp_link_pkg::LANES-1:0][dp_link_pkg::SPL-1:0] rd,
    output msa_pkg::lanes_cfg_t        lanes,
    output logic                       msg_start
);

    import dp_link_pkg::*;
    import msa_pkg::*;

    logic                      acc;         // Request accepted
    logic [MSG_DAT_W-1:0]      word;
    logic [LANES-1:0][SPL-1:0] sel_rd;
    logic [1:0]                lane_a;      // Lane for the high byte
    logic [1:0]                lane_b;      // Lane for the low byte
    logic                      slot;        // First or second symbol

    assign req_ready = ~rsp_valid | rsp_ready;
    assign acc       = req_valid & req_ready;
    assign msg_start = acc & req.first;
    assign rd        = acc ? sel_rd : '0;   // Only taken words step the pointers

    always_comb
    begin
        sel_rd = '0;
        case (lanes)
            LANES_4 :
            begin
                // Bit 0 picks the lane pair, bit 1 the symbol
                lane_a = {req.idx[0], 1'b0};
                lane_b = {req.idx[0], 1'b1};
                slot   = req.idx[1];
            end
            LANES_2 :
            begin
                lane_a = 2'd0;
                lane_b = 2'd1;
                slot   = req.idx[0];
            end
            default :
            begin
                lane_a = 2'd0;
                lane_b = 2'd0;
                slot   = 1'b0;
            end
        endcase

        if (lanes == LANES_4 || lanes == LANES_2)
        begin
            word = slot ? {pair[lane_a].second, pair[lane_b].second}
                        : {pair[lane_a].first, pair[lane_b].first};
            sel_rd[lane_a][slot] = 1'b1;
            sel_rd[lane_b][slot] = 1'b1;
        end
        else
        begin
            word      = {pair[0].first, pair[0].second};  // Both bytes from lane 0
            sel_rd[0] = 2'b11;
        end
    end

    always_ff @(posedge CLK_IN or negedge rst_n)
    begin
        if (!rst_n)
        begin
            lanes     <= LANES_1;
            rsp_valid <= 1'b0;
        end
        else
        begin
            lanes <= ctl_lanes;
            if (acc)
                rsp_valid <= 1'b1;
            else if (rsp_ready)
                rsp_valid <= 1'b0;
        end
    end

    // Loads only on an accepted request
    always_ff @(posedge CLK_IN)
    begin
        if (acc)
            rsp.dat <= word;
    end

    // Stalled word is held until the consumer takes it
    a_rsp_hold : assert property (@(posedge CLK_IN) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

/* msa_irq_ctrl.sv */
module msa_irq_ctrl
(
    input  logic                          CLK_IN,
    input  logic                          rst_n,
    input  logic                          lock,
    input  msa_pkg::lanes_cfg_t           lanes,
    input  logic [dp_link_pkg::LANES-1:0] eop,
    input  logic                          msg_start,
    output logic                          irq
);

    import dp_link_pkg::*;
    import msa_pkg::*;

    logic [LANES-1:0] done;     // Packet finished per lane
    logic [LANES-1:0] active;
    logic             all_done;

    always_comb
    begin
        case (lanes)
            LANES_4 : active = 4'b1111;
            LANES_2 : active = 4'b0011;
            default : active = 4'b0001;
        endcase
    end

    assign all_done = &(done | ~active);    // Unused lanes count as done

    always_ff @(posedge CLK_IN or negedge rst_n)
    begin
        if (!rst_n)
            done <= '0;
        else if (!lock || msg_start)
            done <= '0;
        else
            done <= done | eop;
    end

    always_ff @(posedge CLK_IN or negedge rst_n)
    begin
        if (!rst_n)
            irq <= 1'b0;
        else if (!lock || msg_start)
            irq <= 1'b0;    // New message or link lost
        else if (all_done)
            irq <= 1'b1;
    end

    // Interrupt never survives a clock without lock
    a_irq_lock : assert property (@(posedge CLK_IN) disable iff (!rst_n)
        !lock |=> !irq);

endmodule

/* msa_rx_top.sv */
module msa_rx_top
#(
    parameter int P_RAM_DEPTH = 32
)
(
    input  logic                   CLK_IN,
    input  logic                   rst_n,
    input  dp_link_pkg::lnk_beat_t lnk,
    input  msa_pkg::lanes_cfg_t    ctl_lanes,
    input  msa_pkg::msg_req_t      req,
    input  logic                   req_valid,
    input  logic                   rsp_ready,
    output logic                   req_ready,
    output msa_pkg::msg_rsp_t      rsp,
    output logic                   rsp_valid,
    output logic                   irq
);

    import dp_link_pkg::*;
    import msa_pkg::*;

    sym_pair_t                 pair [LANES];
    logic [LANES-1:0][SPL-1:0] rd;
    logic [LANES-1:0]          eop;
    lanes_cfg_t                lanes;      // Registered lane count
    logic                      msg_start;

    for (genvar i = 0; i < LANES; i++)
    begin : gen_lane
        msa_lane_capture #(
            .P_RAM_DEPTH (P_RAM_DEPTH)
        ) lane_inst (
            .CLK_IN (CLK_IN),
            .rst_n  (rst_n),
            .beat   (lnk.lane[i]),
            .rd     (rd[i]),
            .pair   (pair[i]),
            .eop    (eop[i])
        );
    end

    msa_read_mux read_mux_inst (
        .CLK_IN    (CLK_IN),
        .rst_n     (rst_n),
        .ctl_lanes (ctl_lanes),
        .req       (req),
        .req_valid (req_valid),
        .rsp_ready (rsp_ready),
        .pair      (pair),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rd        (rd),
        .lanes     (lanes),
        .msg_start (msg_start)
    );

    msa_irq_ctrl irq_ctrl_inst (
        .CLK_IN    (CLK_IN),
        .rst_n     (rst_n),
        .lock      (lnk.lock),
        .lanes     (lanes),
        .eop       (eop),
        .msg_start (msg_start),
        .irq       (irq)
    );

endmodule

/* tb_msa_rx.sv */
module tb_msa_rx;

    import dp_link_pkg::*;
    import msa_pkg::*;

    localparam int MAX_CYCLES = 3000;   // All tests need about 300 cycles

    logic       CLK_IN;
    logic       rst_n;
    lnk_beat_t  lnk;
    lanes_cfg_t ctl_lanes;
    msg_req_t   req;
    logic       req_valid;
    logic       rsp_ready;
    logic       req_ready;
    msg_rsp_t   rsp;
    logic       rsp_valid;
    logic       irq;

    logic [31:0]      lfsr = 32'h26eb_408f;
    logic [7:0]       lane_q [LANES][$];    // Sent MSA symbols per lane
    logic [15:0]      exp_dat;              // Word the response register should hold
    logic             acc_first;            // Accepted request with first set
    logic [LANES-1:0] m_flag;
    logic [LANES-1:0] m_done;
    logic             m_irq;
    lanes_cfg_t       m_lanes;
    int               cycles = 0;
    int               n_acc = 0;
    int               n_rsp = 0;
    int               err_cnt [4] = '{0, 0, 0, 0};  // data, handshake, irq, other

    msa_rx_top #(.P_RAM_DEPTH(32)) msa_rx_top_inst (.*);

    initial CLK_IN = 1'b0;
    always #5 CLK_IN = ~CLK_IN;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++)
            b = {b[6:0], lfsr_bit()};
        return b;
    endfunction

    function automatic logic [7:0] pop_sym(input int l);
        if (lane_q[l].size() == 0)
        begin
            err_cnt[3]++;
            $display("Model queue of lane %0d ran empty at time %0t", l, $time);
            return 8'h00;
        end
        return lane_q[l].pop_front();
    endfunction

    task automatic flag_fail(input int kind, input string msg);
        err_cnt[kind]++;
        $display("FAILED at time %0t: %s", $time, msg);
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge CLK_IN);
    endtask

    // Sends 12 symbols per enabled lane
    // Odd lanes start on sublane 1 and end on sublane 0
    task automatic send_packets(input logic [LANES-1:0] en, input logic [LANES-1:0] odd);
        for (int i = 0; i < LANES; i++)
            if (en[i])
                lane_q[i].delete();
        for (int b = 0; b < 8; b++)
        begin
            @(negedge CLK_IN);
            for (int i = 0; i < LANES; i++)
            begin
                lnk.lane[i].dat[0] = rand_byte();
                lnk.lane[i].dat[1] = rand_byte();
                if (!en[i] || b == 7)
                    lnk.lane[i].msa = 2'b00;
                else if (odd[i])
                    lnk.lane[i].msa = (b == 0) ? 2'b10 : (b == 6) ? 2'b01 : 2'b11;
                else
                    lnk.lane[i].msa = (b < 6) ? 2'b11 : 2'b00;
                if (lnk.lane[i].msa[0])
                    lane_q[i].push_back(lnk.lane[i].dat[0]);  // Earlier symbol first
                if (lnk.lane[i].msa[1])
                    lane_q[i].push_back(lnk.lane[i].dat[1]);
            end
        end
    endtask

    // Reads n words in index order over span distinct indices
    task automatic read_words(input int n, input int span, input bit throttle);
        int         k;
        int         hi;
        int         lo;
        logic [7:0] b_hi;
        logic [7:0] b_lo;
        k = 0;
        while (k < n)
        begin
            @(negedge CLK_IN);
            acc_first = 1'b0;
            req_valid = 1'b1;
            req.idx   = MSG_IDX_W'(k % span);
            req.first = (k == 0);
            rsp_ready = throttle ? lfsr_bit() : 1'b1;
            #1;
            if (req_ready)
            begin
                hi   = (span == 4) ? 2 * (k % 2) : 0;   // Lane of the high byte
                lo   = (span == 1) ? 0 : hi + 1;
                b_hi = pop_sym(hi);
                b_lo = pop_sym(lo);
                acc_first = req.first;
                n_acc++;
                k++;
                @(posedge CLK_IN);
                exp_dat <= {b_hi, b_lo};
            end
        end
        @(negedge CLK_IN);
        acc_first = 1'b0;
        req_valid = 1'b0;
        rsp_ready = 1'b1;
    endtask

    task automatic wait_irq(input int limit);
        int n;
        n = 0;
        while (!irq && n < limit)
        begin
            @(negedge CLK_IN);
            n++;
        end
        if (!irq)
        begin
            err_cnt[3]++;
            $display("The interrupt did not rise within %0d cycles", limit);
        end
    endtask

    // Interrupt model with done flags set on the edge after each lane's packet end
    always @(posedge CLK_IN or negedge rst_n)
    begin
        if (!rst_n)
        begin
            m_flag  <= '0;
            m_done  <= '0;
            m_irq   <= 1'b0;
            m_lanes <= LANES_4;
        end
        else
        begin
            m_lanes <= ctl_lanes;
            for (int i = 0; i < LANES; i++)
                m_flag[i] <= |lnk.lane[i].msa;
            if (!lnk.lock || acc_first)
            begin
                m_done <= '0;
                m_irq  <= 1'b0;
            end
            else
            begin
                for (int i = 0; i < LANES; i++)
                    if (m_flag[i] && lnk.lane[i].msa == 2'b00)
                        m_done[i] <= 1'b1;
                if (m_done[0] && (m_lanes == LANES_1 || m_done[1])
                    && (m_lanes != LANES_4 || &m_done[3:2]))
                    m_irq <= 1'b1;
            end
        end
    end

    always @(posedge CLK_IN)
    begin
        cycles <= cycles + 1;
        if (rst_n && rsp_valid && rsp_ready)
            n_rsp <= n_rsp + 1;
        if (cycles == MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    a_rsp_data : assert property (@(posedge CLK_IN) disable iff (!rst_n)
        rsp_valid |-> rsp.dat == exp_dat)
        else flag_fail(0, $sformatf("response %h, expected %h", rsp.dat, exp_dat));
    a_rsp_hold : assert property (@(posedge CLK_IN) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp.dat))
        else flag_fail(1, "stalled response changed or vanished");
    a_req_stall : assert property (@(posedge CLK_IN) disable iff (!rst_n)
        rsp_valid && !rsp_ready |-> !req_ready)
        else flag_fail(1, "req_ready high while the response is stalled");
    a_rsp_latency : assert property (@(posedge CLK_IN) disable iff (!rst_n)
        req_valid && req_ready |=> rsp_valid)
        else flag_fail(1, "no response one clock after an accepted request");
    a_irq_model : assert property (@(posedge CLK_IN) disable iff (!rst_n)
        irq == m_irq)
        else flag_fail(2, $sformatf("irq %b, expected %b", irq, m_irq));
    a_irq_lock : assert property (@(posedge CLK_IN) disable iff (!rst_n)
        !lnk.lock |=> !irq)
        else flag_fail(2, "irq high one clock after lock was low");

    // Lanes outside the active count never see a read strobe
    a_unused_rd : assert property (@(posedge CLK_IN) disable iff (!rst_n)
        (m_lanes == LANES_4 || msa_rx_top_inst.rd[3:2] == '0)
        && (m_lanes != LANES_1 || msa_rx_top_inst.rd[1] == '0))
        else flag_fail(3, "read strobe fired on an unused lane");

    initial
    begin
        rst_n     = 1'b0;
        lnk       = '0;
        lnk.lock  = 1'b1;
        ctl_lanes = LANES_4;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b1;
        acc_first = 1'b0;
        exp_dat   = '0;
        repeat (3) @(negedge CLK_IN);
        rst_n = 1'b1;
        idle(2);

        send_packets(4'b1111, 4'b0000);     // Four lanes in phase 0
        wait_irq(20);
        read_words(12, 4, 1'b0);

        // Lane 2 starts on the odd sublane and is read under back-pressure
        send_packets(4'b1111, 4'b0100);
        wait_irq(20);
        read_words(12, 4, 1'b1);

        ctl_lanes = LANES_2;
        send_packets(4'b1111, 4'b0010);
        wait_irq(20);
        read_words(6, 2, 1'b1);
        ctl_lanes = LANES_1;
        send_packets(4'b0001, 4'b0000);
        wait_irq(20);
        read_words(6, 1, 1'b0);

        // Lane 3 stays silent at first so irq must wait for it
        ctl_lanes = LANES_4;
        send_packets(4'b0111, 4'b0000);
        idle(10);
        send_packets(4'b1000, 4'b1000);
        wait_irq(20);
        lnk.lock = 1'b0;
        idle(2);
        lnk.lock = 1'b1;
        idle(4);

        if (n_rsp != n_acc)
        begin
            err_cnt[3]++;
            $display("Accepted %0d requests but saw %0d responses", n_acc, n_rsp);
        end
        $display("Error counts: data %0d, handshake %0d, irq %0d, other %0d",
                 err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3]);
        if (err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3] == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* flist.f */
dp_link_pkg.sv
msa_pkg.sv
msa_sym_ram.sv
msa_lane_capture.sv
msa_read_mux.sv
msa_irq_ctrl.sv
msa_rx_top.sv
tb_msa_rx.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_msa_rx \
    -f flist.f -Mdir obj_dir -o tb_msa_rx
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_msa_rx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0
